//--- verif/host_stim.txt
# Columns: test name, opcode (0 read, 1 write), address, data word,
#          expected response data, expected finish_o after the request
trace_wr      1 00100 000000000000abcd 0000000000000000 0
trace_rd      0 00100 0000000000000000 0000000000000bcd 0
fin_core0     1 00200 0000000000001100 0000000000000000 1
fin_code_rd   0 00200 0000000000000000 0000000000001100 1
status_rd     0 00300 0000000000000000 0000000000000001 1
fin_core2     1 00200 0000000000002202 0000000000000000 5
fin_bad_core  1 00200 0000000000003307 0000000000000000 5
fin_code_rd2  0 00200 0000000000000000 0000000000002200 5
fin_core1     1 00200 0000000000004401 0000000000000000 7
unmapped_wr   1 00400 000000000000ffff 0000000000000000 7
unmapped_rd   0 00404 0000000000000000 0000000000000000 7
status_wr     1 00300 000000000000000f 0000000000000000 7
status_rd2    0 00300 0000000000000000 0000000000000007 7
fin_core3     1 00200 0000000000005503 0000000000000000 f
status_rd3    0 00300 0000000000000000 000000000000000f f
trace_wr2     1 00100 ffffffffffffffff 0000000000000000 f
trace_rd2     0 00100 0000000000000000 0000000000001fff f
fin_bad_core2 1 00200 000000000000ff04 0000000000000000 f
fin_code_rd3  0 00200 0000000000000000 0000000000005500 f

//--- sim.f
hdl/host_pkg.sv
hdl/host_fwd_decode.sv
hdl/host_reg_file.sv
hdl/host_rev_queue.sv
hdl/host_top.sv
verif/host_properties.sv
verif/host_tb.sv

//--- run.sh
#!/bin/sh
# Build the host device testbench with Verilator and run it from the project root
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module host_tb -o host_sim \
  && ./obj_dir/host_sim | tee /dev/stderr | grep "Simulation passed" > /dev/null \
  && echo "run.sh: passed" \
  || { echo "run.sh: failed"; exit 1; }

//--- verif/host_tb.sv
/* Testbench for host_top: replays verif/host_stim.txt and checks every response and
   the trace and finish outputs, with random reverse back-pressure. */
`default_nettype none

module host_tb;

  import host_pkg::*;

  localparam int num_core_lp  = 4;
  localparam int max_tests_lp = 64;

  logic                              clk_i;
  logic                              rst_n_i;
  host_fwd_header_s                  fwd_header;
  host_data_u                        fwd_data;
  logic                              fwd_v;
  logic                              fwd_ready_and;
  host_rev_header_s                  rev_header;
  logic [host_data_width_gp-1:0]     rev_data;
  logic                              rev_v;
  logic                              rev_ready_and;
  logic [host_trace_en_width_gp-1:0] trace_en;
  logic [num_core_lp-1:0]            finish;
  logic                              all_finished;

  logic [8*24-1:0]                   test_name   [max_tests_lp];
  host_rev_header_s                  test_hdr    [max_tests_lp];
  logic [host_data_width_gp-1:0]     test_data   [max_tests_lp];
  logic [host_data_width_gp-1:0]     test_rsp    [max_tests_lp];
  logic [num_core_lp-1:0]            test_finish [max_tests_lp];
  logic                              test_bad    [max_tests_lp];
  logic [host_trace_en_width_gp-1:0] exp_trace;
  int                                exp_idx_q [$];
  int                                num_tests;
  int                                num_passed;
  int                                num_failed;
  logic                              loaded;

  host_top #(.num_core_p(num_core_lp)) UUT
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.fwd_header_i(fwd_header)
     ,.fwd_data_i(fwd_data)
     ,.fwd_v_i(fwd_v)
     ,.fwd_ready_and_o(fwd_ready_and)
     ,.rev_header_o(rev_header)
     ,.rev_data_o(rev_data)
     ,.rev_v_o(rev_v)
     ,.rev_ready_and_i(rev_ready_and)
     ,.trace_en_o(trace_en)
     ,.finish_o(finish)
     ,.all_finished_o(all_finished)
     );

  always #50 clk_i = ~clk_i;

  // Ready low about a quarter of the time
  initial
    begin
      void'($urandom(2));
      forever
        begin
          @(posedge clk_i);
          rev_ready_and <= (($urandom % 4) != 0);
        end
    end

  task automatic read_stim();
    int               fd;
    int               cnt;
    logic [8*160-1:0] line;
    logic [8*24-1:0]  name;
    logic [31:0]      op;
    logic [31:0]      addr;
    logic [63:0]      data;
    logic [63:0]      rsp;
    logic [31:0]      fin;
    fd = $fopen("verif/host_stim.txt", "r");
    if (fd == 0)
      $display("Cannot open verif/host_stim.txt, no tests run");
    while (fd != 0 && !$feof(fd) && num_tests < max_tests_lp)
      begin
        line = '0;
        cnt  = $fgets(line, fd);
        cnt  = $sscanf(line, "%s %h %h %h %h %h", name, op, addr, data, rsp, fin);
        // Comment and blank lines do not parse fully
        if (cnt == 6)
          begin
            test_name[num_tests]   = name;
            test_hdr[num_tests]    = host_rev_header_s'({op[0], addr[host_addr_width_gp-1:0]});
            test_data[num_tests]   = data;
            test_rsp[num_tests]    = rsp;
            test_finish[num_tests] = fin[num_core_lp-1:0];
            test_bad[num_tests]    = 1'b0;
            num_tests++;
          end
      end
    if (fd != 0)
      $fclose(fd);
  endtask

  task automatic report_test(input logic [8*24-1:0] name, input logic bad);
    if (bad)
      begin
        num_failed++;
        $display("test %0s: FAILED", name);
      end
    else
      begin
        num_passed++;
        $display("test %0s: ok", name);
      end
  endtask

  // Outputs right after the acceptance edge, before any later request commits
  task automatic check_outputs(input int t);
    assert (finish == test_finish[t])
      else
        begin
          $display("Mismatch %0s: finish_o expected %h actual %h", test_name[t],
                   test_finish[t], finish);
          test_bad[t] = 1'b1;
        end
    assert (all_finished == (&test_finish[t]))
      else
        begin
          $display("Mismatch %0s: all_finished_o expected %b actual %b", test_name[t],
                   &test_finish[t], all_finished);
          test_bad[t] = 1'b1;
        end
    assert (trace_en == exp_trace)
      else
        begin
          $display("Mismatch %0s: trace_en_o expected %h actual %h", test_name[t],
                   exp_trace, trace_en);
          test_bad[t] = 1'b1;
        end
  endtask

  task automatic send_request(input int t);
    @(posedge clk_i);
    fwd_header <= host_fwd_header_s'(test_hdr[t]);
    fwd_data   <= host_data_u'(test_data[t]);
    fwd_v      <= 1'b1;
    @(posedge clk_i);
    while (!fwd_ready_and)
      @(posedge clk_i);
    exp_idx_q.push_back(t);
    fwd_v <= 1'b0;
    if (test_hdr[t].msg_type == e_host_wr && test_hdr[t].addr == host_trace_addr_gp)
      exp_trace = test_data[t][host_trace_en_width_gp-1:0];
    @(negedge clk_i);
    check_outputs(t);
  endtask

  task automatic check_response();
    int t;
    if (exp_idx_q.size() == 0)
      begin
        $display("Response arrived with no request pending, address %h", rev_header.addr);
        num_failed++;
      end
    else
      begin
        t = exp_idx_q.pop_front();
        assert (rev_header == test_hdr[t])
          else
            begin
              $display("Mismatch %0s: header expected %h actual %h", test_name[t],
                       test_hdr[t], rev_header);
              test_bad[t] = 1'b1;
            end
        assert (rev_data == test_rsp[t])
          else
            begin
              $display("Mismatch %0s: data expected %h actual %h", test_name[t],
                       test_rsp[t], rev_data);
              test_bad[t] = 1'b1;
            end
        report_test(test_name[t], test_bad[t]);
      end
  endtask

  always @(posedge clk_i)
    begin
      if (rst_n_i && rev_v && rev_ready_and)
        check_response();
    end

  initial
    begin
      logic reset_bad;
      clk_i         = 1'b0;
      rst_n_i       = 1'b0;
      fwd_header    = '0;
      fwd_data      = '0;
      fwd_v         = 1'b0;
      rev_ready_and = 1'b0;
      exp_trace     = '0;
      num_tests     = 0;
      num_passed    = 0;
      num_failed    = 0;
      reset_bad     = 1'b0;
      read_stim();
      if (num_tests == 0)
        num_failed++;
      loaded = 1'b1;
      repeat (4) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      assert (trace_en == '0 && finish == '0 && !all_finished)
        else
          begin
            $display("Mismatch reset_state: outputs expected 0 actual trace %h finish %h done %b",
                     trace_en, finish, all_finished);
            reset_bad = 1'b1;
          end
      assert (!rev_v && fwd_ready_and)
        else
          begin
            $display("After reset a response is pending or requests are refused");
            reset_bad = 1'b1;
          end
      report_test("reset_state", reset_bad);
      for (int t = 0; t < num_tests; t++)
        send_request(t);
      while (exp_idx_q.size() != 0)
        @(posedge clk_i);
      repeat (4) @(posedge clk_i);
      assert (UUT.rev_queue.props.prop_errors == 0)
        else
          begin
            $display("Queue assertions failed %0d times", UUT.rev_queue.props.prop_errors);
            num_failed++;
          end
      $display("Tests: %0d passed, %0d failed", num_passed, num_failed);
      if (num_failed == 0)
        $display("Simulation passed");
      else
        $display("Simulation failed");
      $finish;
    end

  // Watchdog allows 20 cycles per test plus reset
  initial
    begin
      wait (loaded === 1'b1);
      repeat ((num_tests + 1) * 20) @(posedge clk_i);
      $display("Timeout: %0d responses still outstanding", exp_idx_q.size());
      $display("Simulation failed");
      $finish;
    end

endmodule

`default_nettype wire

//--- verif/host_properties.sv
/* Concurrent checks on the reverse response queue, bound into host_rev_queue. */
`default_nettype none

module host_properties
  (input  logic                                   clk_i
   ,input logic                                   rst_n_i
   ,input logic                                   rev_v_i
   ,input logic                                   rev_ready_and_i
   ,input host_pkg::host_rev_header_s             rev_header_i
   ,input logic [host_pkg::host_data_width_gp-1:0] rev_data_i
   ,input logic [1:0]                             count_i
   );

  int prop_errors = 0;

  // Nothing offered while reset is held
  no_valid_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !rev_v_i)
    else
      begin
        $error("rev_v_o high during reset");
        prop_errors++;
      end

  // A stalled response must not change
  hold_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rev_v_i && !rev_ready_and_i) |=>
      (rev_v_i && $stable(rev_header_i) && $stable(rev_data_i)))
    else
      begin
        $error("reverse response changed while stalled");
        prop_errors++;
      end

  count_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i) count_i <= 2'd2)
    else
      begin
        $error("queue count above two");
        prop_errors++;
      end

endmodule

bind host_rev_queue host_properties props
  (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.rev_v_i(rev_v_o)
   ,.rev_ready_and_i(rev_ready_and_i)
   ,.rev_header_i(rev_header_o)
   ,.rev_data_i(rev_data_o)
   ,.count_i(count_r)
   );

`default_nettype wire

//--- hdl/host_top.sv
/* Host device top level: forward decode, register file and reverse response queue.
   num_core_p sets the number of finish flags. */
`default_nettype none

module host_top
  #(parameter int num_core_p = 4)
  (input  logic                                          clk_i
   ,input logic                                          rst_n_i

   ,input host_pkg::host_fwd_header_s                    fwd_header_i
   ,input host_pkg::host_data_u                          fwd_data_i
   ,input logic                                          fwd_v_i
   ,output logic                                         fwd_ready_and_o

   ,output host_pkg::host_rev_header_s                   rev_header_o
   ,output logic [host_pkg::host_data_width_gp-1:0]      rev_data_o
   ,output logic                                         rev_v_o
   ,input logic                                          rev_ready_and_i

   ,output logic [host_pkg::host_trace_en_width_gp-1:0]  trace_en_o
   ,output logic [num_core_p-1:0]                        finish_o
   ,output logic                                         all_finished_o
   );

  import host_pkg::*;

  host_reg_op_s     reg_op;
  host_rev_header_s echo_header;
  host_data_u       rd_data;
  logic             op_v;
  logic             space;

  host_fwd_decode fwd_decode
    (.fwd_header_i(fwd_header_i)
     ,.fwd_data_i(fwd_data_i)
     ,.fwd_v_i(fwd_v_i)
     ,.space_i(space)
     ,.fwd_ready_and_o(fwd_ready_and_o)
     ,.op_v_o(op_v)
     ,.reg_op_o(reg_op)
     ,.rev_header_o(echo_header)
     );

  host_reg_file
   #(.num_core_p(num_core_p))
   reg_file
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.op_v_i(op_v)
     ,.reg_op_i(reg_op)
     ,.rd_data_o(rd_data)
     ,.trace_en_o(trace_en_o)
     ,.finish_o(finish_o)
     ,.all_finished_o(all_finished_o)
     );

  // Response captured on the same edge the register op commits
  host_rev_queue rev_queue
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.push_i(op_v)
     ,.header_i(echo_header)
     ,.data_i(rd_data)
     ,.space_o(space)
     ,.rev_header_o(rev_header_o)
     ,.rev_data_o(rev_data_o)
     ,.rev_v_o(rev_v_o)
     ,.rev_ready_and_i(rev_ready_and_i)
     );

endmodule

`default_nettype wire

//--- hdl/host_rev_queue.sv
/* Two-entry in-order queue for reverse responses.
   Pushes on request acceptance and pops on the reverse valid/ready_and handshake. */
`default_nettype none

module host_rev_queue
  (input  logic                           clk_i
   ,input logic                           rst_n_i

   ,input logic                           push_i
   ,input host_pkg::host_rev_header_s     header_i
   ,input host_pkg::host_data_u           data_i
   ,output logic                          space_o

   ,output host_pkg::host_rev_header_s    rev_header_o
   ,output logic [host_pkg::host_data_width_gp-1:0] rev_data_o
   ,output logic                          rev_v_o
   ,input logic                           rev_ready_and_i
   );

  import host_pkg::*;

  host_rev_header_s                header_mem [2];
  logic [host_data_width_gp-1:0]   data_mem   [2];
  logic [host_data_width_gp-1:0]   push_data;
  logic                            wr_ptr_r;
  logic                            rd_ptr_r;
  logic [1:0]                      count_r;
  logic                            pop;

  assign pop     = rev_v_o & rev_ready_and_i;
  assign space_o = (count_r != 2'd2);
  assign rev_v_o = (count_r != 2'd0);

  // Write acks return no data
  assign push_data = (header_i.msg_type == e_host_wr) ? '0 : data_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        begin
          wr_ptr_r <= 1'b0;
          rd_ptr_r <= 1'b0;
          count_r  <= 2'd0;
        end
      else
        begin
          if (push_i)
            wr_ptr_r <= ~wr_ptr_r;
          if (pop)
            rd_ptr_r <= ~rd_ptr_r;
          case ({push_i, pop})
            2'b10:   count_r <= count_r + 2'd1;
            2'b01:   count_r <= count_r - 2'd1;
            default: count_r <= count_r;
          endcase
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (push_i)
        begin
          header_mem[wr_ptr_r] <= header_i;
          data_mem[wr_ptr_r]   <= push_data;
        end
    end

  assign rev_header_o = header_mem[rd_ptr_r];
  assign rev_data_o   = data_mem[rd_ptr_r];

endmodule

`default_nettype wire

//--- hdl/host_reg_file.sv
/* Host registers: trace enables, per-core finish flags and the last finish code.
   Writes commit on the acceptance edge; read data shows the value before it. */
`default_nettype none

module host_reg_file
  #(parameter int num_core_p = 4)
  (input  logic                                          clk_i
   ,input logic                                          rst_n_i

   ,input logic                                          op_v_i
   ,input host_pkg::host_reg_op_s                        reg_op_i

   ,output host_pkg::host_data_u                         rd_data_o
   ,output logic [host_pkg::host_trace_en_width_gp-1:0]  trace_en_o
   ,output logic [num_core_p-1:0]                        finish_o
   ,output logic                                         all_finished_o
   );

  import host_pkg::*;

  logic [host_trace_en_width_gp-1:0] trace_en_r;
  logic [num_core_p-1:0]             finish_r;
  logic [num_core_p-1:0]             finish_n;
  logic [7:0]                        finish_code_r;
  logic                              all_finished_r;
  logic                              trace_w_v;
  logic                              finish_w_v;
  logic                              core_in_range;

  assign trace_w_v     = op_v_i & reg_op_i.w_v & (reg_op_i.sel == e_reg_trace);
  assign core_in_range = (reg_op_i.data.finish_view.core < num_core_p);
  assign finish_w_v    = op_v_i & reg_op_i.w_v & (reg_op_i.sel == e_reg_finish)
                         & core_in_range;

  // Flags only ever get set
  always_comb
    begin
      finish_n = finish_r;
      for (int i = 0; i < num_core_p; i++)
        begin
          if (finish_w_v && (reg_op_i.data.finish_view.core == i))
            finish_n[i] = 1'b1;
        end
    end

  always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        begin
          trace_en_r     <= '0;
          finish_r       <= '0;
          finish_code_r  <= '0;
          all_finished_r <= 1'b0;
        end
      else
        begin
          if (trace_w_v)
            trace_en_r <= reg_op_i.data.trace_view.en;
          if (finish_w_v)
            finish_code_r <= reg_op_i.data.finish_view.code;
          finish_r       <= finish_n;
          all_finished_r <= &finish_n;
        end
    end

  always_comb
    begin
      rd_data_o = '0;
      case (reg_op_i.sel)
        e_reg_trace:  rd_data_o.trace_view.en    = trace_en_r;
        e_reg_finish: rd_data_o.finish_view.code = finish_code_r;
        e_reg_status: rd_data_o[num_core_p-1:0]  = finish_r;
        default:      rd_data_o = '0;
      endcase
    end

  assign trace_en_o     = trace_en_r;
  assign finish_o       = finish_r;
  assign all_finished_o = all_finished_r;

endmodule

`default_nettype wire

//--- hdl/host_fwd_decode.sv
/* Forward request front end: accepts a request when the response queue has room
   and turns it into a register operation plus the header to echo back. */
`default_nettype none

module host_fwd_decode
  (input  host_pkg::host_fwd_header_s  fwd_header_i
   ,input host_pkg::host_data_u        fwd_data_i
   ,input logic                        fwd_v_i
   ,input logic                        space_i

   ,output logic                       fwd_ready_and_o
   ,output logic                       op_v_o
   ,output host_pkg::host_reg_op_s     reg_op_o
   ,output host_pkg::host_rev_header_s rev_header_o
   );

  import host_pkg::*;

  host_reg_e reg_sel;
  logic      is_write;

  // Ready only depends on queue room, never on valid
  assign fwd_ready_and_o = space_i;
  assign op_v_o          = fwd_v_i & space_i;

  assign is_write = (fwd_header_i.msg_type == e_host_wr);

  always_comb
    begin
      case (fwd_header_i.addr)
        host_trace_addr_gp:  reg_sel = e_reg_trace;
        host_finish_addr_gp: reg_sel = e_reg_finish;
        host_status_addr_gp: reg_sel = e_reg_status;
        default:             reg_sel = e_reg_none;
      endcase
    end

  always_comb
    begin
      reg_op_o.sel  = reg_sel;
      // Status is read only
      reg_op_o.w_v  = is_write & ((reg_sel == e_reg_trace) | (reg_sel == e_reg_finish));
      reg_op_o.data = fwd_data_i;
    end

  always_comb
    begin
      rev_header_o.msg_type = fwd_header_i.msg_type;
      rev_header_o.addr     = fwd_header_i.addr;
    end

endmodule

`default_nettype wire

//--- hdl/host_pkg.sv
/* Shared widths, register map and message types of the host device.
   Modules import it in their body and name its types by scope in their ports. */
`default_nettype none

package host_pkg;

  localparam int host_addr_width_gp     = 20;
  localparam int host_data_width_gp     = 64;
  localparam int host_trace_en_width_gp = 13;

  // Host register map
  localparam logic [host_addr_width_gp-1:0] host_trace_addr_gp  = 20'h0_0100;
  localparam logic [host_addr_width_gp-1:0] host_finish_addr_gp = 20'h0_0200;
  localparam logic [host_addr_width_gp-1:0] host_status_addr_gp = 20'h0_0300;

  typedef enum logic
  {
    e_host_rd = 1'b0
    ,e_host_wr = 1'b1
  } host_msg_e;

  typedef enum logic [1:0]
  {
    e_reg_none    = 2'd0
    ,e_reg_trace  = 2'd1
    ,e_reg_finish = 2'd2
    ,e_reg_status = 2'd3
  } host_reg_e;

  typedef struct packed
  {
    host_msg_e                      msg_type;
    logic [host_addr_width_gp-1:0]  addr;
  } host_fwd_header_s;

  typedef struct packed
  {
    host_msg_e                      msg_type;
    logic [host_addr_width_gp-1:0]  addr;
  } host_rev_header_s;

  // Trace register view with the enables in the low bits
  typedef struct packed
  {
    logic [host_data_width_gp-host_trace_en_width_gp-1:0] unused;
    logic [host_trace_en_width_gp-1:0]                    en;
  } host_trace_view_s;

  // Finish register view
  typedef struct packed
  {
    logic [host_data_width_gp-17:0] unused;
    logic [7:0]                     code;
    logic [7:0]                     core;
  } host_finish_view_s;

  typedef union packed
  {
    host_trace_view_s   trace_view;
    host_finish_view_s  finish_view;
  } host_data_u;

  typedef struct packed
  {
    host_reg_e   sel;
    logic        w_v;
    host_data_u  data;
  } host_reg_op_s;

endpackage

`default_nettype wire
